// File: flist.f
hw/rx_tile_pkg.sv
hw/noc_credit_in.sv
hw/noc_credit_out.sv
hw/noc_fbits_splitter.sv
hw/rx_ptr_table.sv
hw/rx_hdr_extract.sv
hw/rx_tile_top.sv
tb/rx_tile_chk.sv
tb/rx_tile_tb.sv

// File: hw/noc_credit_in.sv
`timescale 1ns/1ps
`default_nettype none

module noc_credit_in (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] credit_data
    ,input  wire logic                              credit_val
    ,output logic                                   credit_yummy

    ,output logic                                   out_val
    ,output logic [rx_tile_pkg::noc_data_w-1:0]     out_data
    ,input  wire logic                              out_rdy
);
    import rx_tile_pkg::*;

    logic [noc_data_w-1:0]      buf_mem [noc_credits];
    logic [credit_ptr_w-1:0]    wr_ptr;
    logic [credit_ptr_w-1:0]    rd_ptr;
    logic                       deq;

    // empty when both pointers agree including the wrap bit
    assign out_val  = wr_ptr != rd_ptr;
    assign out_data = buf_mem[rd_ptr[credit_ptr_w-2:0]];
    assign deq      = out_val & out_rdy;

    // sender credits bound the fill level
    always_ff @(posedge clk) begin
        if (credit_val) begin
            buf_mem[wr_ptr[credit_ptr_w-2:0]] <= credit_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            credit_yummy <= 1'b0;
        end else begin
            if (credit_val) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // one credit back per flit handed on
            credit_yummy <= deq;
        end
    end

endmodule

`default_nettype wire

// File: hw/noc_credit_out.sv
`timescale 1ns/1ps
`default_nettype none

module noc_credit_out (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic                              in_val
    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] in_data
    ,output logic                                   in_rdy

    ,output logic [rx_tile_pkg::noc_data_w-1:0]     credit_data
    ,output logic                                   credit_val
    ,input  wire logic                              credit_yummy
);
    import rx_tile_pkg::*;

    logic [credit_cnt_w-1:0]    credit_cnt;
    logic                       send;

    // stall while the receiver has no room
    assign in_rdy      = credit_cnt != '0;
    assign send        = in_val & in_rdy;
    assign credit_val  = send;
    assign credit_data = in_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_cnt_w'(noc_credits);
        end else if (send && !credit_yummy) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!send && credit_yummy) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/noc_fbits_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module noc_fbits_splitter (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic                              in_val
    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] in_data
    ,output logic                                   in_rdy

    ,output logic                                   ptr_val
    ,output logic [rx_tile_pkg::noc_data_w-1:0]     ptr_data
    ,input  wire logic                              ptr_rdy

    ,output logic                                   hdr_val
    ,output logic [rx_tile_pkg::noc_data_w-1:0]     hdr_data
    ,input  wire logic                              hdr_rdy
);
    import rx_tile_pkg::*;

    typedef enum logic [1:0] {
        route_ptr,
        route_hdr,
        route_drop
    } route_e;

    ptr_flit_t              in_flit;
    route_e                 dec_route;
    route_e                 held_route;
    route_e                 cur_route;
    logic [msg_len_w-1:0]   remaining;
    logic                   mid_msg;

    // fbits and msg_len sit in the same place in every message
    assign in_flit = ptr_flit_t'(in_data);
    assign mid_msg = remaining != '0;

    always_comb begin
        case (in_flit.fbits)
            ptr_if_fbits: dec_route = route_ptr;
            pkt_if_fbits: dec_route = route_hdr;
            default:      dec_route = route_drop;
        endcase
    end

    assign cur_route = mid_msg ? held_route : dec_route;

    assign ptr_val  = in_val & (cur_route == route_ptr);
    assign hdr_val  = in_val & (cur_route == route_hdr);
    assign ptr_data = in_data;
    assign hdr_data = in_data;

    // unknown destinations are swallowed
    assign in_rdy = (cur_route == route_ptr) ? ptr_rdy :
                    (cur_route == route_hdr) ? hdr_rdy : 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining  <= '0;
            held_route <= route_drop;
        end else if (in_val && in_rdy) begin
            if (!mid_msg) begin
                remaining  <= in_flit.msg_len;
                held_route <= dec_route;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_hdr_extract.sv
`timescale 1ns/1ps
`default_nettype none

module rx_hdr_extract (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic                              in_val
    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] in_data
    ,output logic                                   in_rdy

    ,output logic                                   hdr_val
    ,output logic [rx_tile_pkg::ip_addr_w-1:0]      hdr_src_ip
    ,output logic [rx_tile_pkg::ip_addr_w-1:0]      hdr_dst_ip
    ,output logic [rx_tile_pkg::tcp_len_w-1:0]      hdr_tcp_len
    ,input  wire logic                              hdr_rdy
);
    import rx_tile_pkg::*;

    hdr_state_e state;
    hdr_flit0_t first_flit;

    assign first_flit = hdr_flit0_t'(in_data);

    // no new flits until the current header is taken
    assign in_rdy  = state != present;
    assign hdr_val = state == present;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= wait_first;
        end else begin
            case (state)
                wait_first:  if (in_val) state <= wait_second;
                wait_second: if (in_val) state <= present;
                present:     if (hdr_rdy) state <= wait_first;
                default:     state <= wait_first;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_first && in_val) begin
            hdr_tcp_len <= first_flit.tcp_len;
        end
        // second flit carries source then destination address
        if (state == wait_second && in_val) begin
            hdr_src_ip <= in_data[noc_data_w-1 -: ip_addr_w];
            hdr_dst_ip <= in_data[ip_addr_w-1:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_ptr_table.sv
`timescale 1ns/1ps
`default_nettype none

module rx_ptr_table (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic                              req_val
    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] req_data
    ,output logic                                   req_rdy

    ,output logic                                   resp_val
    ,output logic [rx_tile_pkg::noc_data_w-1:0]     resp_data
    ,input  wire logic                              resp_rdy
);
    import rx_tile_pkg::*;

    logic [rx_ptr_w-1:0]    head_ptr   [2**flow_id_w];
    logic [rx_ptr_w-1:0]    commit_ptr [2**flow_id_w];
    ptr_flit_t              req_flit;
    ptr_flit_t              resp_flit;
    logic                   req_fire;
    logic                   is_rd;
    logic [rx_ptr_w-1:0]    rd_value;

    assign req_flit  = ptr_flit_t'(req_data);
    assign req_rdy   = !resp_val;
    assign req_fire  = req_val & req_rdy;
    assign resp_data = resp_flit;

    assign is_rd    = (req_flit.op == ptr_rd_head) || (req_flit.op == ptr_rd_commit);
    assign rd_value = (req_flit.op == ptr_rd_head) ? head_ptr[req_flit.flowid]
                                                   : commit_ptr[req_flit.flowid];

    // flows start with empty buffers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr   <= '{default: '0};
            commit_ptr <= '{default: '0};
        end else if (req_fire && req_flit.op == ptr_wr_head) begin
            head_ptr[req_flit.flowid] <= req_flit.ptr;
        end else if (req_fire && req_flit.op == ptr_wr_commit) begin
            commit_ptr[req_flit.flowid] <= req_flit.ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_val <= 1'b0;
        end else if (req_fire && is_rd) begin
            resp_val <= 1'b1;
        end else if (resp_rdy) begin
            resp_val <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && is_rd) begin
            resp_flit.fbits   <= ptr_resp_fbits;
            resp_flit.msg_len <= '0;
            resp_flit.op      <= ptr_resp;
            resp_flit.flowid  <= req_flit.flowid;
            resp_flit.pad     <= '0;
            resp_flit.ptr     <= rd_value;
        end
    end

endmodule

`default_nettype wire

// File: hw/rx_tile_pkg.sv
`default_nettype none

package rx_tile_pkg;

    localparam int noc_data_w   = 64;
    localparam int flow_id_w    = 4;
    localparam int rx_ptr_w     = 16;
    localparam int ip_addr_w    = 32;
    localparam int tcp_len_w    = 16;
    localparam int msg_len_w    = 8;
    localparam int fbits_w      = 4;
    localparam int noc_credits  = 4;

    // extra pointer bit tells a full buffer from an empty one
    localparam int credit_ptr_w = $clog2(noc_credits) + 1;
    localparam int credit_cnt_w = $clog2(noc_credits + 1);

    localparam logic [fbits_w-1:0] ptr_if_fbits   = 4'd2;
    localparam logic [fbits_w-1:0] pkt_if_fbits   = 4'd3;
    localparam logic [fbits_w-1:0] ptr_resp_fbits = 4'd1;

    typedef enum logic [3:0] {
        ptr_rd_head,
        ptr_wr_head,
        ptr_rd_commit,
        ptr_wr_commit,
        ptr_resp
    } ptr_op_e;

    typedef enum logic [1:0] {
        wait_first,
        wait_second,
        present
    } hdr_state_e;

    typedef struct packed {
        logic [fbits_w-1:0]   fbits;
        logic [msg_len_w-1:0] msg_len;
        ptr_op_e              op;
        logic [flow_id_w-1:0] flowid;
        logic [27:0]          pad;
        logic [rx_ptr_w-1:0]  ptr;
    } ptr_flit_t;

    typedef struct packed {
        logic [fbits_w-1:0]   fbits;
        logic [msg_len_w-1:0] msg_len;
        logic [35:0]          pad;
        logic [tcp_len_w-1:0] tcp_len;
    } hdr_flit0_t;

endpackage

`default_nettype wire

// File: hw/rx_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tile_top (
     input  wire logic                              clk
    ,input  wire logic                              rst_n

    ,input  wire logic [rx_tile_pkg::noc_data_w-1:0] noc_in_data
    ,input  wire logic                              noc_in_val
    ,output logic                                   noc_in_yummy

    ,output logic [rx_tile_pkg::noc_data_w-1:0]     noc_out_data
    ,output logic                                   noc_out_val
    ,input  wire logic                              noc_out_yummy

    ,output logic                                   hdr_val
    ,output logic [rx_tile_pkg::ip_addr_w-1:0]      hdr_src_ip
    ,output logic [rx_tile_pkg::ip_addr_w-1:0]      hdr_dst_ip
    ,output logic [rx_tile_pkg::tcp_len_w-1:0]      hdr_tcp_len
    ,input  wire logic                              hdr_rdy
);
    import rx_tile_pkg::*;

    logic                   ctovr_splitter_val;
    logic [noc_data_w-1:0]  ctovr_splitter_data;
    logic                   splitter_ctovr_rdy;

    logic                   splitter_ptr_val;
    logic [noc_data_w-1:0]  splitter_ptr_data;
    logic                   ptr_splitter_rdy;

    logic                   splitter_hdr_val;
    logic [noc_data_w-1:0]  splitter_hdr_data;
    logic                   hdr_splitter_rdy;

    logic                   ptr_vrtoc_val;
    logic [noc_data_w-1:0]  ptr_vrtoc_data;
    logic                   vrtoc_ptr_rdy;

    noc_credit_in noc_credit_in_inst (
         .clk           (clk                )
        ,.rst_n         (rst_n              )
        ,.credit_data   (noc_in_data        )
        ,.credit_val    (noc_in_val         )
        ,.credit_yummy  (noc_in_yummy       )
        ,.out_val       (ctovr_splitter_val )
        ,.out_data      (ctovr_splitter_data)
        ,.out_rdy       (splitter_ctovr_rdy )
    );

    noc_fbits_splitter noc_fbits_splitter_inst (
         .clk       (clk                )
        ,.rst_n     (rst_n              )
        ,.in_val    (ctovr_splitter_val )
        ,.in_data   (ctovr_splitter_data)
        ,.in_rdy    (splitter_ctovr_rdy )
        ,.ptr_val   (splitter_ptr_val   )
        ,.ptr_data  (splitter_ptr_data  )
        ,.ptr_rdy   (ptr_splitter_rdy   )
        ,.hdr_val   (splitter_hdr_val   )
        ,.hdr_data  (splitter_hdr_data  )
        ,.hdr_rdy   (hdr_splitter_rdy   )
    );

    rx_ptr_table rx_ptr_table_inst (
         .clk       (clk                )
        ,.rst_n     (rst_n              )
        ,.req_val   (splitter_ptr_val   )
        ,.req_data  (splitter_ptr_data  )
        ,.req_rdy   (ptr_splitter_rdy   )
        ,.resp_val  (ptr_vrtoc_val      )
        ,.resp_data (ptr_vrtoc_data     )
        ,.resp_rdy  (vrtoc_ptr_rdy      )
    );

    rx_hdr_extract rx_hdr_extract_inst (
         .clk           (clk                )
        ,.rst_n         (rst_n              )
        ,.in_val        (splitter_hdr_val   )
        ,.in_data       (splitter_hdr_data  )
        ,.in_rdy        (hdr_splitter_rdy   )
        ,.hdr_val       (hdr_val            )
        ,.hdr_src_ip    (hdr_src_ip         )
        ,.hdr_dst_ip    (hdr_dst_ip         )
        ,.hdr_tcp_len   (hdr_tcp_len        )
        ,.hdr_rdy       (hdr_rdy            )
    );

    noc_credit_out noc_credit_out_inst (
         .clk           (clk            )
        ,.rst_n         (rst_n          )
        ,.in_val        (ptr_vrtoc_val  )
        ,.in_data       (ptr_vrtoc_data )
        ,.in_rdy        (vrtoc_ptr_rdy  )
        ,.credit_data   (noc_out_data   )
        ,.credit_val    (noc_out_val    )
        ,.credit_yummy  (noc_out_yummy  )
    );

endmodule

`default_nettype wire

// File: tb/rx_tile_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tile_chk (
     input  wire logic                                  clk
    ,input  wire logic                                  rst_n
    ,input  wire logic [rx_tile_pkg::credit_cnt_w-1:0]  credit_cnt
    ,input  wire logic                                  credit_val
    ,input  wire logic                                  credit_yummy
    ,input  wire logic                                  hdr_val
    ,input  wire logic                                  hdr_rdy
    ,input  wire logic [2*rx_tile_pkg::ip_addr_w+rx_tile_pkg::tcp_len_w-1:0] hdr_fields
);
    import rx_tile_pkg::*;

    logic [credit_cnt_w-1:0]    in_flight;

    // flits sent and not yet returned by a yummy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + credit_cnt_w'(credit_val) - credit_cnt_w'(credit_yummy);
        end
    end

    credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= noc_credits)
        else $error("output credit count above %0d", noc_credits);

    no_send_at_zero: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight == credit_cnt_w'(noc_credits) |-> !credit_val)
        else $error("flit sent with no output credits");

    // header held until taken
    hdr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_val && !hdr_rdy |=> hdr_val && $stable(hdr_fields))
        else $error("header changed or dropped before hdr_rdy");

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !credit_val && !hdr_val)
        else $error("valid high right after reset");

endmodule

bind noc_credit_out rx_tile_chk credit_chk_inst (
     .clk          (clk         )
    ,.rst_n        (rst_n       )
    ,.credit_cnt   (credit_cnt  )
    ,.credit_val   (credit_val  )
    ,.credit_yummy (credit_yummy)
    // this block has no header port
    ,.hdr_val      (1'b0        )
    ,.hdr_rdy      (1'b1        )
    ,.hdr_fields   ('0          )
);

bind rx_hdr_extract rx_tile_chk hdr_chk_inst (
     .clk          (clk                                   )
    ,.rst_n        (rst_n                                 )
    ,.credit_cnt   ('0                                    )
    ,.credit_val   (1'b0                                  )
    ,.credit_yummy (1'b0                                  )
    ,.hdr_val      (hdr_val                               )
    ,.hdr_rdy      (hdr_rdy                               )
    ,.hdr_fields   ({hdr_src_ip, hdr_dst_ip, hdr_tcp_len} )
);

`default_nettype wire

// File: tb/rx_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tile_tb;
    import rx_tile_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic [noc_data_w-1:0]  noc_in_data;
    logic                   noc_in_val;
    logic                   noc_in_yummy;
    logic [noc_data_w-1:0]  noc_out_data;
    logic                   noc_out_val;
    logic                   noc_out_yummy;
    logic                   hdr_val;
    logic [ip_addr_w-1:0]   hdr_src_ip;
    logic [ip_addr_w-1:0]   hdr_dst_ip;
    logic [tcp_len_w-1:0]   hdr_tcp_len;
    logic                   hdr_rdy;

    logic [rx_ptr_w-1:0]    ref_head   [16];
    logic [rx_ptr_w-1:0]    ref_commit [16];
    logic [noc_data_w-1:0]  exp_resp [$];
    logic [79:0]            exp_hdr  [$];
    logic [15:0]            lfsr_state;
    logic [15:0]            stall_lfsr;
    logic                   withhold = 1'b0;
    logic                   stall_en = 1'b0;
    int sent_cnt     = 0;
    int yummy_cnt    = 0;
    int yummy_owed   = 0;
    int yummy_back   = 0;
    int out_cnt      = 0;
    int issued_cnt   = 0;
    int cycle_cnt    = 0;
    int mismatch_cnt = 0;
    int other_cnt    = 0;

    rx_tile_top rx_tile_top_inst (
         .clk           (clk          )
        ,.rst_n         (rst_n        )
        ,.noc_in_data   (noc_in_data  )
        ,.noc_in_val    (noc_in_val   )
        ,.noc_in_yummy  (noc_in_yummy )
        ,.noc_out_data  (noc_out_data )
        ,.noc_out_val   (noc_out_val  )
        ,.noc_out_yummy (noc_out_yummy)
        ,.hdr_val       (hdr_val      )
        ,.hdr_src_ip    (hdr_src_ip   )
        ,.hdr_dst_ip    (hdr_dst_ip   )
        ,.hdr_tcp_len   (hdr_tcp_len  )
        ,.hdr_rdy       (hdr_rdy      )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    // models the pointer table and builds the response a read should give
    function automatic logic [noc_data_w-1:0] ref_ptr_resp(input ptr_op_e op,
            input logic [3:0] fid, input logic [15:0] ptr);
        ptr_flit_t resp;
        resp = '0;
        resp.fbits  = ptr_resp_fbits;
        resp.op     = ptr_resp;
        resp.flowid = fid;
        case (op)
            ptr_wr_head:   ref_head[fid] = ptr;
            ptr_wr_commit: ref_commit[fid] = ptr;
            ptr_rd_head:   resp.ptr = ref_head[fid];
            default:       resp.ptr = ref_commit[fid];
        endcase
        return resp;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
            input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, got %h", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    // waits for an input credit and drives one flit for a cycle
    task automatic send_flit(input logic [noc_data_w-1:0] data);
        while (sent_cnt - yummy_cnt >= noc_credits) @(negedge clk);
        noc_in_data = data;
        noc_in_val  = 1'b1;
        sent_cnt++;
        @(negedge clk);
        noc_in_val  = 1'b0;
    endtask

    task automatic send_ptr(input ptr_op_e op, input logic [3:0] fid, input logic [15:0] ptr);
        ptr_flit_t req;
        logic [noc_data_w-1:0] resp;
        req = '0;
        req.fbits  = ptr_if_fbits;
        req.op     = op;
        req.flowid = fid;
        req.ptr    = ptr;
        resp = ref_ptr_resp(op, fid, ptr);
        if (op == ptr_rd_head || op == ptr_rd_commit) exp_resp.push_back(resp);
        issued_cnt++;
        send_flit(req);
    endtask

    task automatic send_hdr();
        hdr_flit0_t f0;
        logic [31:0] src;
        logic [31:0] dst;
        logic [15:0] len;
        src = rand_bits(32);
        dst = rand_bits(32);
        len = 16'(rand_bits(16));
        f0 = '0;
        f0.fbits   = pkt_if_fbits;
        f0.msg_len = 8'd1;
        f0.tcp_len = len;
        exp_hdr.push_back({src, dst, len});
        issued_cnt++;
        send_flit(f0);
        send_flit({src, dst});
    endtask

    task automatic send_drop(input logic [3:0] fbits, input logic [7:0] len);
        logic [51:0] body;
        body = {20'(rand_bits(20)), rand_bits(32)};
        issued_cnt++;
        send_flit({fbits, len, body});
        for (int i = 0; i < len; i++) send_flit({rand_bits(32), rand_bits(32)});
    endtask

    task automatic wait_idle();
        while (exp_resp.size() != 0 || exp_hdr.size() != 0 || yummy_cnt != sent_cnt ||
               yummy_back != yummy_owed) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (noc_in_yummy === 1'b1) yummy_cnt++;
    end

    // output yummies and header stalls
    always @(negedge clk) begin
        if (rst_n && !withhold && yummy_back < yummy_owed) begin
            noc_out_yummy = 1'b1;
            yummy_back++;
        end else begin
            noc_out_yummy = 1'b0;
        end
        if (stall_en) begin
            hdr_rdy = stall_lfsr[0];
            stall_lfsr = lfsr_step(stall_lfsr);
        end else begin
            hdr_rdy = 1'b1;
        end
    end

    always @(posedge clk) begin : compare
        logic [79:0] exp_h;
        if (rst_n && noc_out_val) begin
            out_cnt++;
            yummy_owed++;
            assert (exp_resp.size() > 0) else begin
                $display("response flit arrived with no read outstanding");
                other_cnt++;
            end
            if (exp_resp.size() > 0) check_value("noc_out_data", exp_resp.pop_front(),
                                                 noc_out_data);
        end
        if (rst_n && hdr_val && hdr_rdy) begin
            assert (exp_hdr.size() > 0) else begin
                $display("header presented with none outstanding");
                other_cnt++;
            end
            if (exp_hdr.size() > 0) begin
                exp_h = exp_hdr.pop_front();
                check_value("hdr_src_ip", exp_h[79:48], hdr_src_ip);
                check_value("hdr_dst_ip", exp_h[47:16], hdr_dst_ip);
                check_value("hdr_tcp_len", exp_h[15:0], hdr_tcp_len);
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt <= 40 * issued_cnt + 200) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d responses and %0d headers still expected",
                 cycle_cnt, exp_resp.size(), exp_hdr.size());
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        int i;
        int base;
        ptr_op_e op;
        logic [3:0] fid;
        logic [15:0] val;
        noc_in_data   = '0;
        noc_in_val    = 1'b0;
        noc_out_yummy = 1'b0;
        hdr_rdy       = 1'b0;
        rst_n         = 1'b0;
        lfsr_state    = 16'd38881;
        stall_lfsr    = 16'd38881;
        for (i = 0; i < 16; i++) begin
            ref_head[i]   = '0;
            ref_commit[i] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // all pointers zero after reset
        for (i = 0; i < 16; i++) begin
            send_ptr(ptr_rd_head, 4'(i), '0);
            send_ptr(ptr_rd_commit, 4'(i), '0);
        end
        wait_idle();

        for (i = 0; i < 24; i++) begin
            op  = (rand_bits(1) != 0) ? ptr_wr_head : ptr_wr_commit;
            fid = 4'(rand_bits(4));
            val = 16'(rand_bits(16));
            send_ptr(op, fid, val);
        end
        for (i = 0; i < 16; i++) begin
            send_ptr(ptr_rd_head, 4'(i), '0);
            send_ptr(ptr_rd_commit, 4'(i), '0);
        end
        wait_idle();

        stall_en = 1'b1;
        for (i = 0; i < 10; i++) send_hdr();
        wait_idle();
        stall_en = 1'b0;

        // unknown destinations mixed with real traffic
        for (i = 0; i < 4; i++) begin
            send_drop(4'hf, 8'd2);
            send_hdr();
            send_drop(4'h0, 8'd0);
            fid = 4'(rand_bits(4));
            val = 16'(rand_bits(16));
            send_ptr(ptr_wr_commit, fid, val);
            send_drop(ptr_resp_fbits, 8'd1);
            send_ptr(ptr_rd_commit, fid, '0);
        end
        wait_idle();

        base = out_cnt;
        withhold = 1'b1;
        for (i = 0; i < 6; i++) begin
            op  = (rand_bits(1) != 0) ? ptr_rd_head : ptr_rd_commit;
            fid = 4'(rand_bits(4));
            send_ptr(op, fid, '0);
        end
        repeat (40) @(negedge clk);
        assert (out_cnt - base == noc_credits) else begin
            $display("%0d responses left with output yummies withheld, expected %0d",
                     out_cnt - base, noc_credits);
            other_cnt++;
        end
        withhold = 1'b0;
        wait_idle();

        assert (yummy_cnt == sent_cnt) else begin
            $display("input yummies %0d do not match flits sent %0d", yummy_cnt, sent_cnt);
            other_cnt++;
        end
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
